//--- Bender.yml
package:
  name: note_recognizer

sources:
  - note_pkg.sv
  - period_meter.sv
  - note_classifier.sv
  - note_filter.sv
  - song_tracker.sv
  - seg_display.sv
  - note_recognizer_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_note_recognizer_assert.sv
      - tb_note_recognizer.sv

//--- note_classifier.sv
`timescale 1ns/1ps

module note_classifier
    import note_pkg::*;
#(
    parameter int CLK_MHZ = 50
)
(
    input  period_t i_period,
    output note_t   o_note
);

    // Period in cycles scaled by pct/100, 64 bits to survive the product
    function automatic period_t bound(input longint freq_100, input longint pct);
        return period_t'(longint'(CLK_MHZ) * 1_000_000 * pct / freq_100);
    endfunction

    //------------------------------------------------------------------------
    // One window per note and octave

    for (genvar n = 0; n < N_NOTES; n++)
    begin : g_note
        logic [2:0] hit;

        for (genvar oct = 0; oct < 3; oct++)
        begin : g_oct
            localparam longint  FREQ = longint'(NOTE_FREQ_100[n]) << oct;
            localparam period_t LO   = bound(FREQ, 99);
            localparam period_t HI   = bound(FREQ, 101);

            assign hit[oct] = (i_period > LO) && (i_period < HI);
        end

        // Position 0 is C, which sits in the MSB
        assign o_note[N_NOTES - 1 - n] = |hit;
    end

endmodule

//--- note_filter.sv
`timescale 1ns/1ps

module note_filter
    import note_pkg::*;
#(
    parameter int HOLD_W = 20
)
(
    input  logic  clk,
    input  logic  rst,
    input  note_t i_note,
    output note_t o_note
);

    note_t             d_note;    // Delayed raw note
    logic [HOLD_W-1:0] hold_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_note   <= NO_NOTE;
            hold_cnt <= '0;
            o_note   <= NO_NOTE;
        end
        else
        begin
            d_note <= i_note;

            if (i_note == d_note)
                hold_cnt <= hold_cnt + 1'b1;
            else
                hold_cnt <= '0;  // Any glitch restarts the hold

            if (&hold_cnt)
                o_note <= d_note;
        end
    end

endmodule

//--- note_pkg.sv
package note_pkg;

    localparam int N_NOTES  = 12;
    localparam int N_SONGS  = 3;
    localparam int SONG_LEN = 15;
    localparam int N_DIGITS = 4;

    typedef logic        [19:0] period_t;  // Clock cycles per waveform period
    typedef logic signed [23:0] sample_t;
    typedef logic        [11:0] note_t;    // One-hot, C in the MSB
    typedef logic        [ 3:0] step_t;
    typedef logic        [ 7:0] seg_t;     // abcdefgh

    typedef struct packed {
        step_t step_song0;
        step_t step_song1;
        step_t step_song2;
    } song_steps_t;

    localparam step_t STEP_RECOGNIZED = 4'hf;

    //------------------------------------------------------------------------
    // Note codes

    localparam note_t NO_NOTE = 12'b0000_0000_0000;
    localparam note_t NOTE_C  = 12'b1000_0000_0000;
    localparam note_t NOTE_CS = 12'b0100_0000_0000;
    localparam note_t NOTE_D  = 12'b0010_0000_0000;
    localparam note_t NOTE_DS = 12'b0001_0000_0000;
    localparam note_t NOTE_E  = 12'b0000_1000_0000;
    localparam note_t NOTE_F  = 12'b0000_0100_0000;
    localparam note_t NOTE_FS = 12'b0000_0010_0000;
    localparam note_t NOTE_G  = 12'b0000_0001_0000;
    localparam note_t NOTE_GS = 12'b0000_0000_1000;
    localparam note_t NOTE_A  = 12'b0000_0000_0100;
    localparam note_t NOTE_AS = 12'b0000_0000_0010;
    localparam note_t NOTE_B  = 12'b0000_0000_0001;

    localparam note_t NOTE_DF = NOTE_CS;
    localparam note_t NOTE_EF = NOTE_DS;
    localparam note_t NOTE_GF = NOTE_FS;
    localparam note_t NOTE_AF = NOTE_GS;
    localparam note_t NOTE_BF = NOTE_AS;

    // Measured on the board, B is off the standard pitch
    localparam int unsigned NOTE_FREQ_100 [N_NOTES] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 50000
    };

    //------------------------------------------------------------------------
    // Melodies: love story, godfather, gangsters

    localparam note_t SONG_NOTES [N_SONGS][SONG_LEN] = '{
        '{NOTE_BF, NOTE_D,  NOTE_BF, NOTE_D,  NOTE_EF, NOTE_D,  NOTE_C,  NOTE_A,
          NOTE_C,  NOTE_A,  NOTE_C,  NOTE_D,  NOTE_C,  NOTE_BF, NOTE_G},
        '{NOTE_G,  NOTE_C,  NOTE_EF, NOTE_D,  NOTE_C,  NOTE_EF, NOTE_C,  NOTE_D,
          NOTE_C,  NOTE_AF, NOTE_BF, NOTE_G,  NOTE_C,  NOTE_EF, NOTE_D},
        '{NOTE_E,  NOTE_F,  NOTE_E,  NOTE_A,  NOTE_B,  NOTE_C,  NOTE_D,  NOTE_C,
          NOTE_B,  NOTE_C,  NOTE_G,  NOTE_C,  NOTE_A,  NOTE_C,  NOTE_A}
    };

    //------------------------------------------------------------------------
    // Segment patterns

    localparam seg_t NOTE_SEG [N_NOTES] = '{
        8'b10011100, 8'b10011101, 8'b01111010, 8'b01111011,  // C C# D D#
        8'b10011110, 8'b10001110, 8'b10001111, 8'b10111100,  // E F F# G
        8'b10111101, 8'b11101110, 8'b11101111, 8'b00111110   // G# A A# B
    };

    localparam seg_t HEX_SEG [16] = '{
        8'b11111100, 8'b01100000, 8'b11011010, 8'b11110010,
        8'b01100110, 8'b10110110, 8'b10111110, 8'b11100000,
        8'b11111110, 8'b11100110, 8'b11101110, 8'b00111110,
        8'b10011100, 8'b01111010, 8'b10011110,
        8'b11000110                                          // Upper o
    };

    localparam seg_t SEG_NO_NOTE = 8'b00000010;  // Dash

endpackage

//--- note_recognizer_top.sv
`timescale 1ns/1ps

module note_recognizer_top
    import note_pkg::*;
#(
    parameter int CLK_MHZ   = 50,
    parameter int HOLD_W    = 20,
    parameter int REFRESH_W = 16
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          i_key,
    input  sample_t             i_mic,
    output logic [3:0]          o_led,
    output seg_t                o_abcdefgh,
    output logic [N_DIGITS-1:0] o_digit
);

    period_t     period;
    note_t       raw_note;
    note_t       note;
    logic        clear;
    step_t       steps [N_SONGS];
    song_steps_t song_steps;
    logic [3:0]  new_led;

    assign clear = |i_key;

    //------------------------------------------------------------------------
    // Pitch chain

    period_meter period_meter_i (
        .clk(clk), .rst(rst), .i_mic(i_mic), .o_period(period)
    );

    note_classifier #(.CLK_MHZ(CLK_MHZ)) note_classifier_i (
        .i_period(period), .o_note(raw_note)
    );

    note_filter #(.HOLD_W(HOLD_W)) note_filter_i (
        .clk(clk), .rst(rst), .i_note(raw_note), .o_note(note)
    );

    for (genvar s = 0; s < N_SONGS; s++)
    begin : g_song
        song_tracker #(.SONG(s)) song_tracker_i (
            .clk(clk), .rst(rst), .i_clear(clear), .i_note(note), .o_step(steps[s])
        );
    end

    assign song_steps = '{step_song0: steps[0], step_song1: steps[1], step_song2: steps[2]};

    seg_display #(.REFRESH_W(REFRESH_W)) seg_display_i (
        .clk(clk), .rst(rst), .i_note(note), .i_steps(song_steps),
        .o_digit(o_digit), .o_abcdefgh(o_abcdefgh)
    );

    //------------------------------------------------------------------------
    // LEDs

    always_comb
    begin
        for (int i = 0; i < N_SONGS; i++)
            new_led[3 - i] = (steps[i] == STEP_RECOGNIZED);
        new_led[0] = &new_led[3:1];  // All songs
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_led <= '0;
        else
            o_led <= new_led;
    end

endmodule

//--- period_meter.sv
`timescale 1ns/1ps

module period_meter
    import note_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t i_mic,
    output period_t o_period
);

    sample_t prev_mic;
    period_t counter;
    logic    crossing;

    // Sign goes from negative to positive
    assign crossing = prev_mic[$left(prev_mic)] & ~i_mic[$left(i_mic)];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_mic <= '0;
            counter  <= '0;
            o_period <= '0;
        end
        else
        begin
            prev_mic <= i_mic;

            if (crossing)
            begin
                o_period <= counter;
                counter  <= '0;
            end
            else if (counter != '1)
                counter <= counter + 1'b1;
            else
                o_period <= '1;  // Silence reads as the longest period
        end
    end

endmodule

//--- seg_display.sv
`timescale 1ns/1ps

module seg_display
    import note_pkg::*;
#(
    parameter int REFRESH_W = 16
)
(
    input  logic                clk,
    input  logic                rst,
    input  note_t               i_note,
    input  song_steps_t         i_steps,
    output logic [N_DIGITS-1:0] o_digit,
    output seg_t                o_abcdefgh
);

    localparam int IDX_W = $clog2(N_DIGITS);

    logic [REFRESH_W-1:0] refresh_cnt;
    logic                 tick;
    logic [IDX_W-1:0]     idx;
    logic [IDX_W-1:0]     idx_next;
    seg_t                 seg_next;

    function automatic seg_t note_to_seg(input note_t note);
        seg_t seg;
        seg = SEG_NO_NOTE;
        for (int i = 0; i < N_NOTES; i++)
            if (note == note_t'(1 << (N_NOTES - 1 - i)))
                seg = NOTE_SEG[i];
        return seg;
    endfunction

    //------------------------------------------------------------------------
    // Refresh timing

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign tick     = &refresh_cnt;
    assign idx_next = idx + 1'b1;

    //------------------------------------------------------------------------
    // Digit content

    always_comb
    begin
        case (idx_next)
            2'd3:    seg_next = note_to_seg(i_note);
            2'd2:    seg_next = HEX_SEG[i_steps.step_song0];
            2'd1:    seg_next = HEX_SEG[i_steps.step_song1];
            default: seg_next = HEX_SEG[i_steps.step_song2];
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idx        <= '0;
            o_digit    <= '0;
            o_abcdefgh <= '0;
        end
        else if (tick)
        begin
            idx        <= idx_next;
            o_digit    <= {{(N_DIGITS - 1){1'b0}}, 1'b1} << idx_next;
            o_abcdefgh <= seg_next;  // Same edge as the select
        end
    end

endmodule

//--- song_tracker.sv
`timescale 1ns/1ps

module song_tracker
    import note_pkg::*;
#(
    parameter int SONG = 0
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  i_clear,
    input  note_t i_note,
    output step_t o_step
);

    note_t expected;
    logic  advance;

    // Nothing left to match once recognized
    assign expected = (o_step == STEP_RECOGNIZED) ? NO_NOTE
                                                  : SONG_NOTES[SONG][o_step];

    assign advance = (o_step != STEP_RECOGNIZED) && (i_note == expected);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_step <= '0;
        else if (i_clear)
            o_step <= '0;
        else if (advance)
            o_step <= o_step + 1'b1;  // Step 14 rolls into recognized
    end

endmodule

//--- sources.f
note_pkg.sv
period_meter.sv
note_classifier.sv
note_filter.sv
song_tracker.sv
seg_display.sv
note_recognizer_top.sv
tb_clock.sv
tb_note_recognizer_assert.sv
tb_note_recognizer.sv

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb_note_recognizer.sv
`timescale 1ns/1ps

module tb_note_recognizer
    import note_pkg::*;
();

    localparam int SCAN_CYCLES = 2 * N_DIGITS * 4 + 4;  // Two refresh rounds at REFRESH_W 2
    localparam int OFF_LEN     = 5000;                  // Longer than every note window

    logic       clk;
    logic       rst;
    logic [3:0] i_key;
    sample_t    i_mic;
    logic [3:0] o_led;
    seg_t       o_abcdefgh;
    logic [3:0] o_digit;

    logic [15:0] lfsr       = 16'd12;
    int          errors     = 0;
    int          checks     = 0;
    int          cur_len    = 0;
    int          model_note = -1;  // Accepted note position or -1 for none
    int          model_step [N_SONGS] = '{0, 0, 0};

    tb_clock tb_clock_i (.clk(clk), .rst(rst));

    note_recognizer_top #(.CLK_MHZ(1), .HOLD_W(6), .REFRESH_W(2)) note_recognizer_top_i (
        .clk(clk), .rst(rst), .i_key(i_key), .i_mic(i_mic),
        .o_led(o_led), .o_abcdefgh(o_abcdefgh), .o_digit(o_digit)
    );

    //------------------------------------------------------------------------
    // Stimulus helpers

    // Galois LFSR with taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // Meter reads one cycle less than the tone, so this lands on the window centre
    function automatic int tone_len(input int n, input int oct);
        return 100_000_000 / (NOTE_FREQ_100[n] << oct) + 1;
    endfunction

    function automatic int note_index(input note_t note);
        int idx;
        idx = -1;
        for (int i = 0; i < N_NOTES; i++)
            if (note[N_NOTES - 1 - i])
                idx = i;
        return idx;
    endfunction

    // Positive half first, so every crossing closes a whole period of one tone
    task automatic play_tone(input int len, input int periods);
        for (int p = 0; p < periods; p++)
            for (int c = 0; c < len; c++)
            begin
                @(negedge clk);
                i_mic = {c >= len - len / 2, 23'(rand_bits(23))};
            end
    endtask

    task automatic model_accept(input int n);
        model_note = n;
        for (int s = 0; s < N_SONGS; s++)
            if (n >= 0 && model_step[s] != STEP_RECOGNIZED
                    && note_index(SONG_NOTES[s][model_step[s]]) == n)
                model_step[s]++;
    endtask

    task automatic play_note(input int n, input int oct);
        cur_len = tone_len(n, oct);
        play_tone(cur_len, 4);
        model_accept(n);
    endtask

    //------------------------------------------------------------------------
    // Checkers

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    // Last value seen per digit wins, which comes from the second round
    task automatic check_display();
        logic [N_DIGITS-1:0] seen;
        seg_t                shown [N_DIGITS];
        seg_t                want;
        seen = '0;
        for (int t = 0; t < SCAN_CYCLES; t++)
        begin
            @(negedge clk);
            for (int d = 0; d < N_DIGITS; d++)
                if (o_digit == 4'(1 << d))
                begin
                    seen[d]  = 1'b1;
                    shown[d] = o_abcdefgh;
                end
        end
        if (seen != '1)
        begin
            errors++;
            $display("Display never selected some of its digits, seen %b", seen);
        end
        for (int d = 0; d < N_DIGITS; d++)
        begin
            if (d == 3)
                want = (model_note < 0) ? SEG_NO_NOTE : NOTE_SEG[model_note];
            else
                want = HEX_SEG[model_step[2 - d]];  // Digit 2 is song 0
            check_value($sformatf("o_abcdefgh[digit %0d]", d), shown[d], want);
        end
    endtask

    task automatic check_led();
        logic [3:0] want;
        for (int s = 0; s < N_SONGS; s++)
            want[3 - s] = (model_step[s] == STEP_RECOGNIZED);
        want[0] = &want[3:1];
        check_value("o_led", o_led, want);
    endtask

    // Keep the tone going while the display scans, so no gap reaches the meter
    task automatic settle_and_check();
        fork
            play_tone(cur_len, 1);
            begin
                check_display();
                check_led();
            end
        join
    endtask

    task automatic end_test(input string name, input int mark);
        if (errors == mark)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errors - mark);
    endtask

    //------------------------------------------------------------------------
    // Test sequence

    initial
    begin
        int mark;
        int n;
        int want;
        int guard;
        i_key = '0;
        i_mic = '0;

        guard = 0;
        while (rst !== 1'b0 && guard < 100)
        begin
            @(negedge clk);
            guard++;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset was never released");
            $display("SIMULATION FAILED");
            $finish;
        end

        mark = errors;
        check_value("o_led", o_led, '0);
        check_value("o_digit", o_digit, '0);
        check_value("o_abcdefgh", o_abcdefgh, '0);
        check_display();
        play_tone(40, 3);  // Short primer flushes the count since reset
        end_test("reset", mark);

        mark = errors;
        play_note(rand_bits(4) % N_NOTES, rand_bits(2) % 3);
        settle_and_check();
        end_test("held note", mark);

        mark = errors;
        cur_len = OFF_LEN;
        play_tone(cur_len, 4);
        model_accept(-1);
        settle_and_check();
        end_test("off-window tone", mark);

        mark = errors;
        guard = 0;
        while (model_step[0] != STEP_RECOGNIZED && guard < 40)
        begin
            n    = rand_bits(4) % N_NOTES;
            want = note_index(SONG_NOTES[0][model_step[0]]);
            if (n != want && rand_bits(1) == 1)
                play_note(n, rand_bits(2) % 3);  // Wrong note in between
            play_note(want, rand_bits(2) % 3);
            guard++;
        end
        settle_and_check();
        end_test("song 0", mark);

        mark = errors;
        for (int s = 1; s < N_SONGS; s++)
            for (int k = 0; k < SONG_LEN && model_step[s] != STEP_RECOGNIZED; k++)
                play_note(note_index(SONG_NOTES[s][model_step[s]]), rand_bits(2) % 3);
        settle_and_check();
        end_test("all songs", mark);

        mark = errors;
        cur_len = OFF_LEN;
        play_tone(cur_len, 4);
        model_accept(-1);
        fork
            play_tone(cur_len, 1);
            begin
                @(negedge clk);
                i_key = 4'(1 << rand_bits(2));
                @(negedge clk);
                i_key = '0;
                for (int s = 0; s < N_SONGS; s++)
                    model_step[s] = 0;
                model_accept(model_note);
                check_display();
                check_led();
            end
        join
        end_test("key clear", mark);

        if (note_recognizer_top_i.assert_i.fail_count != 0)
        begin
            errors++;
            $display("Bound assertions failed %0d times",
                     note_recognizer_top_i.assert_i.fail_count);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb_note_recognizer_assert.sv
`timescale 1ns/1ps

module tb_note_recognizer_assert
    import note_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic [3:0]  i_digit,
    input logic [3:0]  i_led,
    input song_steps_t i_steps
);

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // A tracker only moves forward, or back to the first step on a key
    property p_step_forward(step_t step);
        @(posedge clk) disable iff (rst)
            (step >= $past(step)) || (step == '0);
    endproperty

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(i_digit))
        else
        begin
            fail_count++;
            $error("o_digit has more than one digit selected");
        end

    // All three trackers recognized on the cycle before
    a_led_all: assert property (@(posedge clk) disable iff (rst)
        i_led[0] == $past((i_steps.step_song0 == STEP_RECOGNIZED)
                       && (i_steps.step_song1 == STEP_RECOGNIZED)
                       && (i_steps.step_song2 == STEP_RECOGNIZED)))
        else
        begin
            fail_count++;
            $error("o_led[0] does not follow the three recognized songs");
        end

    a_step0: assert property (p_step_forward(i_steps.step_song0))
        else
        begin
            fail_count++;
            $error("Song 0 step went backwards");
        end

    a_step1: assert property (p_step_forward(i_steps.step_song1))
        else
        begin
            fail_count++;
            $error("Song 1 step went backwards");
        end

    a_step2: assert property (p_step_forward(i_steps.step_song2))
        else
        begin
            fail_count++;
            $error("Song 2 step went backwards");
        end

endmodule

bind note_recognizer_top tb_note_recognizer_assert assert_i (
    .clk(clk), .rst(rst), .i_digit(o_digit), .i_led(o_led), .i_steps(song_steps)
);
